// File: uart_rx_pkg.sv
// Shared types for the serial byte receiver with the data byte, the push struct and the FSM phases
`default_nettype none

package uart_rx_pkg;

	// one received data byte
	typedef logic [7:0] byte_t; // 8 data bits of an 8N1 frame

	// byte handed from the bit sampler to the byte buffer
	typedef struct packed
	{
		byte_t data; // assembled byte, LSB received first
		logic strobe; // high for exactly one cycle per byte
	} rx_push_t; // 9 bits in total

	// phases of the bit sampler FSM
	typedef enum logic [1:0]
	{
		phase_idle = 2'd0, // line high, waiting for a start bit
		phase_start = 2'd1, // half-bit wait to the start bit centre
		phase_data = 2'd2, // sampling the 8 data bits
		phase_stop = 2'd3 // waiting for the stop bit centre
	} rx_phase_e;

	// in phase_idle the baud timer is held and RTS may follow the buffer
	// level, in every other phase the timer runs and RTS is frozen

endpackage : uart_rx_pkg

`default_nettype wire

// File: uart_bit_sampler.sv
// RS232 bit sampler that synchronises the receive line, assembles 8N1 bytes and drives RTS
`timescale 1ns/1ns
`default_nettype none

module uart_bit_sampler
	import uart_rx_pkg::*;
#(
	parameter int CLOCK_FREQ = 50_000_000, // clock frequency in Hz
	parameter int BAUD_RATE = 115_200 // line rate in bits per second
)
(
	input wire clock,
	input wire resetn, // asynchronous and active low
	input wire rxd_pin, // from the TXD pin of the sender
	input wire almost_full, // buffer is close to full
	output logic rtsn_pin, // to the CTSn pin of the sender
	output rx_push_t push // byte plus one-cycle strobe toward the buffer
);

	localparam int CLKS_PER_BIT = CLOCK_FREQ / BAUD_RATE; // clocks in one bit time
	localparam int CLKS_HALF = CLKS_PER_BIT / 2; // clocks in half a bit time
	localparam int BAUD_W = $clog2(CLKS_PER_BIT); // width of the baud timer

	typedef logic [BAUD_W-1:0] baud_cnt_t; // baud timer value
	typedef logic [2:0] bit_idx_t; // index of the data bit being sampled

	// the timer counts down to zero, a load of N gives a tick N+1 cycles later
	localparam baud_cnt_t FULL_LOAD = baud_cnt_t'(CLKS_PER_BIT - 1); // one bit time
	localparam baud_cnt_t HALF_LOAD = baud_cnt_t'(CLKS_HALF - 2); // minus the sync delay

	if (CLKS_PER_BIT < 4)
	begin : g_rate_check
		$error("uart_bit_sampler needs at least 4 clocks per bit");
	end

	logic rxd_meta; // first synchroniser stage
	logic rxd_sync; // second stage, safe to use in the FSM
	rx_phase_e phase; // receiver FSM state
	baud_cnt_t baud_cnt; // down-counting baud timer
	logic baud_tick; // one cycle at every bit centre
	bit_idx_t bit_idx; // data bit counter
	logic last_bit; // sampling data bit 7 in this cycle
	byte_t shift_q; // data shift register
	logic strobe_q; // registered byte strobe

	// two flops against metastability on the asynchronous pin
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			rxd_meta <= 1'b1; // idle line level
			rxd_sync <= 1'b1;
		end
		else
		begin
			rxd_meta <= rxd_pin;
			rxd_sync <= rxd_meta;
		end
	end

	assign baud_tick = (phase != phase_idle) && (baud_cnt == '0); // timer expired
	assign last_bit = (phase == phase_data) && (bit_idx == 3'd7); // MSB of the byte

	// baud timer held at the half-bit count while idle, so the first tick lands
	// in the middle of the start bit and every later tick one bit time on
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			baud_cnt <= FULL_LOAD;
		else if (phase == phase_idle)
			baud_cnt <= HALF_LOAD; // armed for the next start edge
		else if (baud_tick)
			baud_cnt <= FULL_LOAD; // next bit centre
		else
			baud_cnt <= baud_cnt - 1'b1;
	end

	// receiver FSM
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			phase <= phase_idle;
		else
		begin
			case (phase)
			phase_idle:
				if (!rxd_sync)
					phase <= phase_start; // falling edge of the start bit
			phase_start:
				if (baud_tick)
					phase <= phase_data; // start bit centre reached
			phase_data:
				if (baud_tick && last_bit)
					phase <= phase_stop; // all 8 bits are in
			phase_stop:
				if (baud_tick)
					phase <= phase_idle; // stop bit centre, line is high again
			default:
				phase <= phase_idle;
			endcase
		end
	end

	// data bit counter
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			bit_idx <= '0;
		else if (phase == phase_start)
			bit_idx <= '0; // fresh frame
		else if (phase == phase_data && baud_tick)
			bit_idx <= bit_idx + 3'd1; // wraps to 0 after bit 7
	end

	// LSB arrives first, so new bits enter at the top
	always_ff @(posedge clock)
	begin
		if (phase == phase_data && baud_tick)
			shift_q <= {rxd_sync, shift_q[7:1]};
	end

	// strobe in the cycle after the bit 7 sample, when shift_q holds the byte
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			strobe_q <= 1'b0;
		else
			strobe_q <= baud_tick && last_bit;
	end

	assign push = '{data: shift_q, strobe: strobe_q};

	// RTS only follows the buffer between frames, so it never toggles mid-frame
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			rtsn_pin <= 1'b0; // sending allowed
		else if (phase == phase_idle)
			rtsn_pin <= almost_full;
	end

	a_strobe_single: assert property (@(posedge clock) disable iff (!resetn)
		push.strobe |=> !push.strobe)
		else $error("uart_bit_sampler: strobe high on two cycles in a row");

	a_start_on_low: assert property (@(posedge clock) disable iff (!resetn)
		(phase == phase_idle) && rxd_sync |=> (phase == phase_idle))
		else $error("uart_bit_sampler: frame started on a high line");

endmodule : uart_bit_sampler

`default_nettype wire

// File: rx_byte_fifo.sv
// Byte buffer with push input, valid/ready output, fill level, almost-full and sticky overflow
`timescale 1ns/1ns
`default_nettype none

module rx_byte_fifo
	import uart_rx_pkg::*;
#(
	parameter int DEPTH_LOG2 = 4 // depth is 2**DEPTH_LOG2 bytes
)
(
	input wire clock,
	input wire resetn, // asynchronous and active low
	input wire rx_push_t push, // byte and write strobe from the sampler
	output byte_t data, // head of the buffer
	output logic valid, // data holds a byte
	input wire ready, // consumer takes the byte
	output logic almost_full, // two or fewer places left
	output logic overflow // a byte was dropped since reset
);

	localparam int DEPTH = 1 << DEPTH_LOG2; // number of byte places

	typedef logic [DEPTH_LOG2-1:0] addr_t; // memory address
	typedef logic [DEPTH_LOG2:0] ptr_t; // address plus wrap bit
	typedef logic [DEPTH_LOG2:0] level_t; // 0 to DEPTH inclusive

	localparam level_t AFULL_LEVEL = level_t'(DEPTH - 2); // room for bytes in flight
	localparam level_t FULL_LEVEL = level_t'(DEPTH);

	if (DEPTH_LOG2 < 2)
	begin : g_depth_check
		$error("rx_byte_fifo needs a depth of at least 4");
	end

	byte_t mem [DEPTH]; // circular byte storage
	ptr_t wr_ptr; // next place to write
	ptr_t rd_ptr; // place of the head byte
	addr_t wr_addr;
	addr_t rd_addr;
	level_t level; // bytes held
	level_t level_next; // bytes held after this edge
	logic empty;
	logic full;
	logic wr_en; // byte accepted
	logic rd_en; // byte handed out

	assign wr_addr = wr_ptr[DEPTH_LOG2-1:0];
	assign rd_addr = rd_ptr[DEPTH_LOG2-1:0];

	// equal pointers mean empty, equal addresses with different wrap bits mean full
	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_addr == rd_addr) && (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]);

	assign wr_en = push.strobe && !full; // full buffer drops the byte
	assign rd_en = valid && ready; // stream transfer

	assign valid = !empty;
	assign data = mem[rd_addr]; // only changes on a pop

	// storage written on the strobe edge
	always_ff @(posedge clock)
	begin
		if (wr_en)
			mem[wr_addr] <= push.data;
	end

	// pointers
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// fill level for the current write and pop
	always_comb
	begin
		case ({wr_en, rd_en})
		2'b10:
			level_next = level + 1'b1; // write only
		2'b01:
			level_next = level - 1'b1; // pop only
		default:
			level_next = level; // both or neither
		endcase
	end

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			level <= '0;
		else
			level <= level_next;
	end

	// almost-full in step with the level, low after reset so RTS allows sending
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			almost_full <= 1'b0;
		else
			almost_full <= (level_next >= AFULL_LEVEL);
	end

	// sticky until reset
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			overflow <= 1'b0;
		else if (push.strobe && full)
			overflow <= 1'b1; // byte lost
	end

	a_level_bound: assert property (@(posedge clock) disable iff (!resetn)
		level <= FULL_LEVEL)
		else $error("rx_byte_fifo: fill level above depth");

	a_hold_stable: assert property (@(posedge clock) disable iff (!resetn)
		valid && !ready |=> valid && $stable(data))
		else $error("rx_byte_fifo: data changed while stalled");

endmodule : rx_byte_fifo

`default_nettype wire

// File: uart_stream_rx.sv
// RS232 receiver top that turns the serial line into a buffered valid/ready byte stream
`timescale 1ns/1ns
`default_nettype none

module uart_stream_rx
	import uart_rx_pkg::*;
#(
	parameter int CLOCK_FREQ = 50_000_000, // clock frequency in Hz
	parameter int BAUD_RATE = 115_200, // line rate in bits per second
	parameter int DEPTH_LOG2 = 4 // buffer holds 2**DEPTH_LOG2 bytes
)
(
	input wire clock,
	input wire resetn, // asynchronous and active low
	input wire rxd_pin, // from the TXD pin of the sender
	output logic rtsn_pin, // to the CTSn pin of the sender
	output byte_t data, // stream byte
	output logic valid, // stream byte present
	input wire ready, // stream consumer accepts
	output logic overflow // sticky lost-byte flag
);

	rx_push_t push; // byte from the sampler into the buffer
	logic almost_full; // buffer level back to the sampler for RTS

	// serial side
	// the sampler freezes RTS during a frame, so it rises at the next idle line
	uart_bit_sampler #(
		.CLOCK_FREQ(CLOCK_FREQ),
		.BAUD_RATE(BAUD_RATE)
	) u_sampler (
		.clock(clock),
		.resetn(resetn),
		.rxd_pin(rxd_pin),
		.almost_full(almost_full),
		.rtsn_pin(rtsn_pin),
		.push(push)
	);

	// stream side
	// two spare places take the bytes a sender still has in flight once RTS rises
	rx_byte_fifo #(
		.DEPTH_LOG2(DEPTH_LOG2)
	) u_fifo (
		.clock(clock),
		.resetn(resetn),
		.push(push),
		.data(data),
		.valid(valid),
		.ready(ready),
		.almost_full(almost_full),
		.overflow(overflow)
	);

endmodule : uart_stream_rx

`default_nettype wire

// File: tb_serial_source.sv
// Testbench serial transmitter that sends queued bytes as 8N1 frames and can honour RTS
`timescale 1ns/1ns
`default_nettype none

module tb_serial_source
	import uart_rx_pkg::*;
#(
	parameter int CLKS_PER_BIT = 16 // clocks in one bit time
)
(
	input wire clock,
	input wire honour_rts, // 1 waits for rtsn_pin low before each start bit
	input wire rtsn_pin, // from the receiver, high asks for a pause
	output logic txd, // serial line into the receiver
	output logic line_idle, // line high between frames, stop bit included
	output logic sent_strobe, // one cycle as a start bit goes out
	output byte_t sent_byte // byte of that frame
);

	byte_t send_q [$]; // bytes waiting to go out
	int gap_q [$]; // idle cycles before each of them
	logic active; // a byte is in its gap, its RTS wait or on the line

	task automatic enqueue(input byte_t b, input int gap);
		send_q.push_back(b);
		gap_q.push_back(gap);
	endtask

	function automatic logic drained();
		return (send_q.size() == 0) && !active;
	endfunction

	// one level held for a full bit time
	task automatic hold_bit(input logic level);
		txd <= level;
		repeat (CLKS_PER_BIT) @(posedge clock);
	endtask

	task automatic send_frame(input byte_t b);
		txd <= 1'b0; // start bit
		line_idle <= 1'b0;
		sent_strobe <= 1'b1; // scoreboard takes the byte here
		sent_byte <= b;
		@(posedge clock);
		sent_strobe <= 1'b0;
		repeat (CLKS_PER_BIT - 1) @(posedge clock);
		for (int i = 0; i < 8; i++)
			hold_bit(b[i]); // LSB first
		line_idle <= 1'b1; // stop bit, line stays high from here
		hold_bit(1'b1);
	endtask

	initial
	begin
		byte_t b;
		int gap;
		txd = 1'b1; // idle line level
		line_idle = 1'b1;
		sent_strobe = 1'b0;
		sent_byte = '0;
		active = 1'b0;
		forever
		begin
			@(posedge clock);
			if (send_q.size() != 0)
			begin
				active = 1'b1;
				b = send_q.pop_front();
				gap = gap_q.pop_front();
				repeat (gap) @(posedge clock); // idle time between frames
				while (honour_rts && rtsn_pin)
					@(posedge clock); // RTS only looked at before a start bit
				send_frame(b);
				active = 1'b0;
			end
		end
	end

endmodule : tb_serial_source

`default_nettype wire

// File: tb_uart_stream_rx.sv
// Testbench for the serial byte receiver covering ordering, back-pressure, RTS and overflow
`timescale 1ns/1ns
`default_nettype none

module tb_uart_stream_rx
	import uart_rx_pkg::*;
();

	localparam int CLOCK_FREQ = 1_000_000;
	localparam int BAUD_RATE = 62_500;
	localparam int DEPTH_LOG2 = 3;
	localparam int DEPTH = 8; // 2**DEPTH_LOG2
	localparam int CLKS_PER_BIT = 16; // CLOCK_FREQ / BAUD_RATE
	localparam logic [31:0] SEED = 32'd26955;
	localparam int N_RANDOM = 40; // in-order run
	localparam int N_STALL = 24; // random ready run
	localparam int N_FLOW = 20; // RTS run
	localparam int N_OVER = 12; // overflow run
	localparam int TOTAL_BYTES = N_RANDOM + N_STALL + N_FLOW + N_OVER;
	localparam int CYCLE_LIMIT = TOTAL_BYTES * 10 * CLKS_PER_BIT * 2 + 2000;

	logic clock;
	logic resetn;
	logic rxd_pin;
	logic rtsn_pin;
	byte_t data;
	logic valid;
	logic ready;
	logic overflow;

	logic honour_rts; // sender mode
	logic line_idle; // sender reports no frame on the line
	logic sent_strobe;
	byte_t sent_byte;
	logic ready_random; // ready follows the random pattern
	logic ready_hold; // ready level otherwise
	logic overflow_expected; // overflow run in progress
	byte_t scoreboard [$]; // bytes put on the line, oldest first
	int popped = 0; // bytes taken from the stream
	int cycle_count = 0;
	logic [31:0] byte_rng = SEED;
	logic [31:0] ready_rng = SEED;
	rx_phase_e sampler_phase;

	assign sampler_phase = UUT.u_sampler.phase; // for messages only

	uart_stream_rx #(
		.CLOCK_FREQ(CLOCK_FREQ),
		.BAUD_RATE(BAUD_RATE),
		.DEPTH_LOG2(DEPTH_LOG2)
	) UUT (
		.clock(clock),
		.resetn(resetn),
		.rxd_pin(rxd_pin),
		.rtsn_pin(rtsn_pin),
		.data(data),
		.valid(valid),
		.ready(ready),
		.overflow(overflow)
	);

	tb_serial_source #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) source (
		.clock(clock),
		.honour_rts(honour_rts),
		.rtsn_pin(rtsn_pin),
		.txd(rxd_pin),
		.line_idle(line_idle),
		.sent_strobe(sent_strobe),
		.sent_byte(sent_byte)
	);

	task automatic stop_with_failure(input string line);
		$display("%s", line);
		$display("TEST FAILED");
		$fatal(1, "first error, run stopped");
	endtask

	task automatic report_mismatch(input string msg);
		stop_with_failure($sformatf("MISMATCH at %0t ns: %s", $time, msg));
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic queue_random_bytes(input int count, input int max_gap);
		int gap;
		for (int i = 0; i < count; i++)
		begin
			byte_rng = xorshift32(byte_rng);
			gap = int'(byte_rng[15:8]) % (max_gap + 1);
			source.enqueue(byte_rng[7:0], gap);
		end
	endtask

	task automatic apply_reset();
		@(posedge clock);
		resetn <= 1'b0;
		repeat (16) @(posedge clock);
		resetn <= 1'b1;
		@(posedge clock); // first cycle out of reset
		if (rtsn_pin !== 1'b0 || valid !== 1'b0 || overflow !== 1'b0)
			report_mismatch("rtsn_pin, valid or overflow not 0 right after reset");
	endtask

	// sender empty, every byte popped, stream empty
	task automatic wait_drained();
		do
			@(posedge clock);
		while (!(source.drained() && scoreboard.size() == 0 && !valid));
	endtask

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock; // 10 ns period
	end

	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == CYCLE_LIMIT)
			stop_with_failure($sformatf("timeout, run not done after %0d cycles", CYCLE_LIMIT));
	end

	// consumer side ready
	always @(posedge clock)
	begin
		if (ready_random)
		begin
			ready_rng = xorshift32(ready_rng);
			ready <= ready_rng[3];
		end
		else
			ready <= ready_hold;
	end

	always @(posedge clock)
	begin
		if (sent_strobe)
			scoreboard.push_back(sent_byte);
	end

	always @(posedge clock)
	begin : pop_compare
		byte_t expected;
		if (resetn && valid && ready)
		begin
			if (scoreboard.size() == 0)
				stop_with_failure("a byte came out of the stream that the sender never sent");
			else
			begin
				expected = scoreboard.pop_front();
				if (data !== expected)
					report_mismatch($sformatf("popped 0x%02h, expected 0x%02h", data, expected));
				popped <= popped + 1;
			end
		end
	end

	// registers only hold their reset values after the first edge
	a_reset_quiet: assert property (@(posedge clock)
		!resetn && cycle_count != 0 |-> !rtsn_pin && !valid && !overflow)
		else report_mismatch("rtsn_pin, valid or overflow high during reset");

	a_stall_hold: assert property (@(posedge clock) disable iff (!resetn)
		valid && !ready |=> valid && $stable(data))
		else report_mismatch("valid or data changed while ready was low");

	a_no_overflow: assert property (@(posedge clock) disable iff (!resetn || overflow_expected)
		!overflow)
		else report_mismatch("overflow set with no byte pushed into a full buffer");

	a_overflow_sticky: assert property (@(posedge clock) disable iff (!resetn)
		overflow |=> overflow)
		else report_mismatch("overflow fell without a reset");

	// sync stages plus the RTS register put the change 4 cycles after the line state
	a_rts_between_frames: assert property (@(posedge clock) disable iff (!resetn)
		$changed(rtsn_pin) |-> $past(line_idle, 4))
		else report_mismatch($sformatf("rtsn_pin changed mid-frame, sampler in %s",
			sampler_phase.name()));

	initial
	begin
		int pop_base;
		resetn = 1'b0;
		ready = 1'b0;
		honour_rts = 1'b0;
		ready_random = 1'b0;
		ready_hold = 1'b0;
		overflow_expected = 1'b0;
		apply_reset();

		ready_hold <= 1'b1; // in-order delivery, consumer always ready
		queue_random_bytes(N_RANDOM, 15);
		wait_drained();

		ready_random <= 1'b1; // random back-pressure
		queue_random_bytes(N_STALL, 3);
		wait_drained();
		ready_random <= 1'b0;

		ready_hold <= 1'b0; // flow control with an honouring sender
		honour_rts <= 1'b1;
		queue_random_bytes(N_FLOW, 0);
		while (!rtsn_pin)
			@(posedge clock);
		repeat (4 * CLKS_PER_BIT) @(posedge clock); // sender reaches its RTS check
		if (source.drained())
			stop_with_failure("sender was not paused by RTS, all bytes went out with ready low");
		ready_hold <= 1'b1;
		wait_drained();

		honour_rts <= 1'b0; // overflow with a sender that ignores RTS
		ready_hold <= 1'b0;
		apply_reset();
		scoreboard.delete();
		overflow_expected = 1'b1;
		queue_random_bytes(N_OVER, 0);
		do
			@(posedge clock);
		while (!source.drained());
		@(posedge clock);
		if (overflow !== 1'b1)
			report_mismatch("overflow low after 12 bytes into a buffer of 8");
		pop_base = popped;
		ready_hold <= 1'b1;
		do
			@(posedge clock);
		while (valid !== 1'b0);
		repeat (2) @(posedge clock);
		if (popped - pop_base != DEPTH)
			report_mismatch($sformatf("%0d bytes drained, expected %0d", popped - pop_base, DEPTH));

		$display("TEST PASSED");
		$finish;
	end

endmodule : tb_uart_stream_rx

`default_nettype wire

// File: tb.f
uart_rx_pkg.sv
uart_bit_sampler.sv
rx_byte_fifo.sv
uart_stream_rx.sv
tb_serial_source.sv
tb_uart_stream_rx.sv
